//--- filelist.f
logic/drum_pkg.sv
logic/tempo_timer.sv
logic/pattern_regs.sv
logic/step_sequencer.sv
logic/voice_player.sv
logic/voice_mixer.sv
logic/drum_machine.sv
sim/drum_checker.sv
sim/drum_machine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := drum_machine_tb
FILELIST  := filelist.f
FLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/drum_machine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module drum_machine_tb;
	import drum_pkg::*;

	localparam int SAMPLE_DIV = 3;
	localparam int BEAT_UNIT  = 4;
	localparam int NUM_PLAYS  = 4;
	localparam int MAX_PERIOD = 4 * BEAT_UNIT; // tempo kept in 0..3

	logic                  clk;
	logic                  rst_n;
	logic                  play;
	logic                  cfg_valid;
	logic                  cfg_ready;
	cfg_addr_t             cfg_addr;
	logic [7:0]            cfg_data;
	logic                  audio_ready;
	logic                  audio_valid;
	mix_t                  audio_data;
	logic [NUM_VOICES-1:0] trig;
	logic [STEP_BITS-1:0]  step;

	int unsigned lcg_state = 32'd46982;
	int          play_len [NUM_PLAYS]; // steps per play phase
	int          limit = 0;
	int          cycles = 0;
	int          tb_errs = 0;
	int          err_mark = 0;
	int          err_cnt;
	int          acc_cnt;
	int          drop_cnt;

	drum_machine #(.SAMPLE_DIV(SAMPLE_DIV), .BEAT_UNIT(BEAT_UNIT)) i_dut (.*);

	drum_checker #(.SAMPLE_DIV(SAMPLE_DIV), .BEAT_UNIT(BEAT_UNIT)) i_check (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (limit > 0 && cycles >= limit)
		begin
			$display("timeout after %0d cycles, test sequence did not finish", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 8;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic cfg_write(input cfg_addr_t addr, input logic [7:0] data);
		int waited;
		waited    = 0;
		cfg_valid = 1'b1;
		cfg_addr  = addr;
		cfg_data  = data;
		while (!cfg_ready && waited < 8)
		begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!cfg_ready)
		begin
			$display("cfg_ready stayed low, write to address %0d was not taken", addr);
			tb_errs++;
		end
		@(posedge clk); // handshake on this edge
		#2;
		cfg_valid = 1'b0;
	endtask

	// hold play high until n step changes were seen
	task automatic play_steps(input int n, input logic gaps);
		int                   seen;
		logic [STEP_BITS-1:0] last;
		seen = 0;
		last = step;
		play = 1'b1;
		while (seen < n)
		begin
			@(posedge clk);
			#2;
			if (gaps)
				audio_ready = (next_rand() % 3 == 0);
			if (step != last)
				seen++;
			last = step;
		end
	endtask

	task automatic report_test(input int num, input string name);
		int errs;
		errs = tb_errs + err_cnt - err_mark;
		$display("test %0d %s: %s, %0d errors", num, name,
			(errs == 0) ? "passed" : "failed", errs);
		err_mark = tb_errs + err_cnt;
	endtask

	initial
	begin
		logic [2:0] a;
		logic [7:0] d;
		int         acc_before;
		int         drop_before;
		rst_n       = 1'b0;
		play        = 1'b0;
		cfg_valid   = 1'b0;
		cfg_addr    = '0;
		cfg_data    = '0;
		audio_ready = 1'b0;
		for (int i = 0; i < NUM_PLAYS; i++)
		begin
			play_len[i] = 9 + int'(next_rand() % 16);
			limit += play_len[i] * MAX_PERIOD;
		end
		limit += 1500; // reset, config writes and idle gaps
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		wait_cycles(12); // play low, nobody taking frames yet
		report_test(1, "reset state");

		audio_ready = 1'b1;
		repeat (12)
		begin
			a = 3'(next_rand());
			d = 8'(next_rand());
			if (a == CFG_TEMPO)
				d = d & 8'd3;
			cfg_write(a, d);
		end
		report_test(2, "config back-pressure");

		cfg_write(CFG_TEMPO, 8'(next_rand() % 4));
		play_steps(play_len[0], 1'b0);
		report_test(3, "step triggers");

		// stop somewhere inside a step, restart at a new tempo
		wait_cycles(1 + int'(next_rand() % 6));
		play = 1'b0;
		wait_cycles(4);
		cfg_write(CFG_TEMPO, 8'(next_rand() % 4));
		play_steps(play_len[1], 1'b0);
		play = 1'b0;
		wait_cycles(3);
		report_test(4, "play stop and restart");

		for (int v = 0; v < NUM_VOICES; v++)
			cfg_write(3'(v), 8'(next_rand()));
		acc_before = acc_cnt;
		play_steps(play_len[2], 1'b0);
		play = 1'b0;
		wait_cycles(3);
		if (acc_cnt == acc_before)
		begin
			$display("no audio frame was accepted while playing");
			tb_errs++;
		end
		report_test(5, "audio frames");

		acc_before  = acc_cnt;
		drop_before = drop_cnt;
		play_steps(play_len[3], 1'b1);
		play        = 1'b0;
		audio_ready = 1'b1;
		wait_cycles(2 * SAMPLE_DIV);
		if (drop_cnt == drop_before || acc_cnt == acc_before)
		begin
			$display("expected accepted and overwritten frames, got %0d and %0d",
				acc_cnt - acc_before, drop_cnt - drop_before);
			tb_errs++;
		end
		report_test(6, "output back-pressure");

		$display("summary: %0d errors, %0d frames accepted, %0d frames dropped",
			tb_errs + err_cnt, acc_cnt, drop_cnt);
		if (tb_errs + err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/drum_checker.sv
`timescale 1ns/1ps
`default_nettype none

module drum_checker #(
	parameter int SAMPLE_DIV = 3,
	parameter int BEAT_UNIT  = 4
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            play,
	input  logic                            cfg_valid,
	input  logic                            cfg_ready,
	input  drum_pkg::cfg_addr_t             cfg_addr,
	input  logic [7:0]                      cfg_data,
	input  logic                            audio_ready,
	input  logic                            audio_valid,
	input  drum_pkg::mix_t                  audio_data,
	input  logic [drum_pkg::NUM_VOICES-1:0] trig,
	input  logic [drum_pkg::STEP_BITS-1:0]  step,
	output int                              err_cnt,
	output int                              acc_cnt,
	output int                              drop_cnt
);
	import drum_pkg::*;

	pattern_t              m_pat [NUM_VOICES];
	logic [STEP_BITS-1:0]  m_step;
	logic [NUM_VOICES-1:0] m_trig;
	logic [NUM_VOICES-1:0] m_hit;
	logic                  m_ready;
	logic                  m_play_q;
	logic                  m_fire;  // step changed, trig due next cycle
	logic                  m_valid;
	int                    m_tempo;
	int                    m_tq;    // tempo taken at period start
	int                    m_per;   // cycles into the step period
	int                    m_div;
	int                    lvl [NUM_VOICES];
	int                    hcnt [NUM_VOICES];
	logic                  neg [NUM_VOICES];
	mix_t                  exp_frame; // model value of the pending frame

	task automatic show_mismatch(input string name, input int got, input int exp);
		$display("mismatch %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
		err_cnt++;
	endtask

	always @(posedge clk)
	begin : model
		logic tick;
		logic stick;
		int   sum;
		if (!rst_n)
		begin
			m_ready   = 1'b0;
			m_play_q  = 1'b0;
			m_fire    = 1'b0;
			m_valid   = 1'b0;
			m_step    = '0;
			m_trig    = '0;
			m_tempo   = 0;
			m_tq      = 0;
			m_per     = 0;
			m_div     = 0;
			exp_frame = '0;
			err_cnt   = 0;
			acc_cnt   = 0;
			drop_cnt  = 0;
			for (int v = 0; v < NUM_VOICES; v++)
			begin
				m_pat[v] = '0;
				lvl[v]   = 0;
				hcnt[v]  = 0;
				neg[v]   = 1'b0;
			end
		end
		else
		begin
			tick  = (m_div == SAMPLE_DIV - 1);
			stick = play && (m_per == (m_tq + 1) * BEAT_UNIT - 1);
			sum   = 0;
			// outputs as they stood before this edge
			if (cfg_ready != m_ready)
				show_mismatch("cfg_ready", int'(cfg_ready), int'(m_ready));
			if (trig != m_trig)
				show_mismatch("trig", int'(trig), int'(m_trig));
			if (step != m_step)
				show_mismatch("step", int'(step), int'(m_step));
			if (audio_valid != m_valid)
				show_mismatch("audio_valid", int'(audio_valid), int'(m_valid));
			if (audio_valid && audio_ready)
			begin
				acc_cnt++;
				if (audio_data != exp_frame)
					show_mismatch("audio_data", int'($unsigned(audio_data)),
						int'($unsigned(exp_frame)));
			end
			m_div = tick ? 0 : m_div + 1;
			if (!play || stick)
			begin
				m_per = 0;
				m_tq  = m_tempo;
			end
			else
				m_per++;
			// voices restart on the observed trig
			for (int v = 0; v < NUM_VOICES; v++)
			begin
				sum += neg[v] ? -lvl[v] : lvl[v];
				if (trig[v])
				begin
					lvl[v]  = int'(VOICE_PEAK[v]);
					hcnt[v] = 0;
					neg[v]  = 1'b0;
				end
				else if (tick && hcnt[v] == int'(VOICE_HALF[v]) - 1)
				begin
					hcnt[v] = 0;
					neg[v]  = !neg[v];
					lvl[v]  = (lvl[v] > int'(VOICE_DECAY[v]))
						? lvl[v] - int'(VOICE_DECAY[v]) : 0;
				end
				else if (tick)
					hcnt[v]++;
			end
			if (tick)
			begin
				if (m_valid && !audio_ready)
					drop_cnt++; // old frame overwritten
				exp_frame = mix_t'(sum);
				m_valid   = 1'b1;
			end
			else if (audio_ready)
				m_valid = 1'b0;
			for (int v = 0; v < NUM_VOICES; v++)
				m_hit[v] = m_pat[v][m_step];
			if (!play)
			begin
				m_step = '0;
				m_fire = 1'b0;
				m_trig = '0;
			end
			else
			begin
				m_trig = m_fire ? m_hit : '0;
				m_fire = !m_play_q || stick;
				if (!m_play_q)
					m_step = '0;
				else if (stick)
					m_step = STEP_BITS'((int'(m_step) + 1) % NUM_STEPS);
			end
			m_play_q = play;
			// register writes show up after this edge
			if (cfg_valid && m_ready)
			begin
				case (cfg_addr)
					CFG_PAT0:  m_pat[0] = cfg_data;
					CFG_PAT1:  m_pat[1] = cfg_data;
					CFG_PAT2:  m_pat[2] = cfg_data;
					CFG_PAT3:  m_pat[3] = cfg_data;
					CFG_TEMPO: m_tempo  = int'(cfg_data);
					default:   ; // write to an unused address is dropped
				endcase
			end
			m_ready = !(cfg_valid && m_ready);
		end
	end

endmodule

`default_nettype wire

//--- logic/drum_machine.sv
`timescale 1ns/1ps
`default_nettype none

module drum_machine #(
	parameter int SAMPLE_DIV = 1042,  // about 48 kHz from 50 MHz
	parameter int BEAT_UNIT  = 62500
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            play,
	input  logic                            cfg_valid,
	input  drum_pkg::cfg_addr_t             cfg_addr,
	input  logic [7:0]                      cfg_data,
	output logic                            cfg_ready,
	input  logic                            audio_ready,
	output logic                            audio_valid,
	output drum_pkg::mix_t                  audio_data,
	output logic [drum_pkg::NUM_VOICES-1:0] trig,
	output logic [drum_pkg::STEP_BITS-1:0]  step
);
	import drum_pkg::*;

	pattern_t pat0, pat1, pat2, pat3;
	tempo_t   tempo;
	logic     sample_tick;
	logic     step_tick;
	// voice outputs into the mixer
	sample_t  kick_sample, snare_sample, hat_sample, clap_sample;

	tempo_timer #(
		.SAMPLE_DIV(SAMPLE_DIV),
		.BEAT_UNIT (BEAT_UNIT)
	) i_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.play       (play),
		.tempo      (tempo),
		.sample_tick(sample_tick),
		.step_tick  (step_tick)
	);

	pattern_regs i_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg_valid(cfg_valid),
		.cfg_ready(cfg_ready),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.pat0     (pat0),
		.pat1     (pat1),
		.pat2     (pat2),
		.pat3     (pat3),
		.tempo    (tempo)
	);

	step_sequencer i_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.play     (play),
		.step_tick(step_tick),
		.pat0     (pat0),
		.pat1     (pat1),
		.pat2     (pat2),
		.pat3     (pat3),
		.trig     (trig),
		.step     (step)
	);

	voice_player #(.VOICE(0)) i_kick (
		.clk(clk), .rst_n(rst_n), .sample_tick(sample_tick),
		.trig(trig[0]), .sample(kick_sample)
	);

	voice_player #(.VOICE(1)) i_snare (
		.clk(clk), .rst_n(rst_n), .sample_tick(sample_tick),
		.trig(trig[1]), .sample(snare_sample)
	);

	voice_player #(.VOICE(2)) i_hat (
		.clk(clk), .rst_n(rst_n), .sample_tick(sample_tick),
		.trig(trig[2]), .sample(hat_sample)
	);

	voice_player #(.VOICE(3)) i_clap (
		.clk(clk), .rst_n(rst_n), .sample_tick(sample_tick),
		.trig(trig[3]), .sample(clap_sample)
	);

	voice_mixer i_mixer (
		.clk        (clk),
		.rst_n      (rst_n),
		.sample_tick(sample_tick),
		.s0         (kick_sample),
		.s1         (snare_sample),
		.s2         (hat_sample),
		.s3         (clap_sample),
		.audio_ready(audio_ready),
		.audio_valid(audio_valid),
		.audio_data (audio_data)
	);

endmodule

`default_nettype wire

//--- logic/voice_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module voice_mixer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sample_tick,
	input  drum_pkg::sample_t s0,
	input  drum_pkg::sample_t s1,
	input  drum_pkg::sample_t s2,
	input  drum_pkg::sample_t s3,
	input  logic              audio_ready,
	output logic              audio_valid,
	output drum_pkg::mix_t    audio_data
);
	import drum_pkg::*;

	mix_t mix_sum;

	// sign-extend before adding, four 8-bit voices fit in 10 bits
	assign mix_sum = mix_t'(s0) + mix_t'(s1) + mix_t'(s2) + mix_t'(s3);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			audio_valid <= 1'b0;
		else if (sample_tick)
			audio_valid <= 1'b1; // new frame, old one dropped if still pending
		else if (audio_ready)
			audio_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (sample_tick)
			audio_data <= mix_sum;
	end

endmodule

`default_nettype wire

//--- logic/voice_player.sv
`timescale 1ns/1ps
`default_nettype none

module voice_player #(
	parameter int VOICE = 0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sample_tick,
	input  logic              trig,
	output drum_pkg::sample_t sample
);
	import drum_pkg::*;

	localparam logic [7:0] PEAK  = VOICE_PEAK[VOICE];
	localparam logic [7:0] HALF  = VOICE_HALF[VOICE];
	localparam logic [7:0] DECAY = VOICE_DECAY[VOICE];

	logic [7:0] level;     // envelope magnitude
	logic [7:0] half_cnt;  // sample ticks into the current half period
	logic       phase_neg;
	logic       half_end;

	assign half_end = (half_cnt == HALF - 8'd1);

	// level never exceeds 127, so the signed view is exact
	assign sample = phase_neg ? -sample_t'(level) : sample_t'(level);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			level     <= '0;
			half_cnt  <= '0;
			phase_neg <= 1'b0;
		end
		else if (trig)
		begin
			// restart even in the middle of a decay
			level     <= PEAK;
			half_cnt  <= '0;
			phase_neg <= 1'b0;
		end
		else if (sample_tick)
		begin
			if (half_end)
			begin
				half_cnt  <= '0;
				phase_neg <= ~phase_neg;
				if (level > DECAY)
					level <= level - DECAY;
				else
					level <= '0; // saturate, voice goes silent
			end
			else
				half_cnt <= half_cnt + 8'd1;
		end
	end

endmodule

`default_nettype wire

//--- logic/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              play,
	input  logic                              step_tick,
	input  drum_pkg::pattern_t                pat0,
	input  drum_pkg::pattern_t                pat1,
	input  drum_pkg::pattern_t                pat2,
	input  drum_pkg::pattern_t                pat3,
	output logic [drum_pkg::NUM_VOICES-1:0]   trig,
	output logic [drum_pkg::STEP_BITS-1:0]    step
);
	import drum_pkg::*;

	logic                  play_q;
	logic                  play_rise;
	logic                  fire;     // step just changed, trigger on next edge
	logic [NUM_VOICES-1:0] hit;

	assign play_rise = play & ~play_q;

	// pattern bits at the current step, voice 0 in bit 0
	assign hit = {pat3[step], pat2[step], pat1[step], pat0[step]};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			play_q <= 1'b0;
		else
			play_q <= play;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || !play)
		begin
			step <= '0;
			fire <= 1'b0;
			trig <= '0;
		end
		else
		begin
			fire <= play_rise | step_tick;
			if (play_rise)
				step <= '0; // restart from the top of the bar
			else if (step_tick)
			begin
				if (step == STEP_BITS'(NUM_STEPS - 1))
					step <= '0;
				else
					step <= step + 1'b1;
			end
			trig <= fire ? hit : '0; // one-cycle pulse
		end
	end

endmodule

`default_nettype wire

//--- logic/pattern_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cfg_valid,
	output logic                cfg_ready,
	input  drum_pkg::cfg_addr_t cfg_addr,
	input  logic [7:0]          cfg_data,
	output drum_pkg::pattern_t  pat0,
	output drum_pkg::pattern_t  pat1,
	output drum_pkg::pattern_t  pat2,
	output drum_pkg::pattern_t  pat3,
	output drum_pkg::tempo_t    tempo
);
	import drum_pkg::*;

	logic accept;

	assign accept = cfg_valid & cfg_ready;

	// one idle cycle after every accepted write
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cfg_ready <= 1'b0;
		else
			cfg_ready <= ~accept;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pat0  <= '0;
			pat1  <= '0;
			pat2  <= '0;
			pat3  <= '0;
			tempo <= '0;
		end
		else if (accept)
		begin
			case (cfg_addr)
				CFG_PAT0:  pat0  <= cfg_data; // kick
				CFG_PAT1:  pat1  <= cfg_data; // snare
				CFG_PAT2:  pat2  <= cfg_data; // hat
				CFG_PAT3:  pat3  <= cfg_data; // clap
				CFG_TEMPO: tempo <= cfg_data;
				default:
				begin
					// unused address, write is taken and dropped
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/tempo_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tempo_timer #(
	parameter int SAMPLE_DIV = 1042,
	parameter int BEAT_UNIT  = 62500
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             play,
	input  drum_pkg::tempo_t tempo,
	output logic             sample_tick,
	output logic             step_tick
);
	import drum_pkg::*;

	localparam int DIV_W  = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
	localparam int BEAT_W = (BEAT_UNIT > 1) ? $clog2(BEAT_UNIT) : 1;

	logic [DIV_W-1:0]  div_cnt;
	logic [BEAT_W-1:0] beat_cnt;
	tempo_t            unit_cnt; // beat units done in this step
	tempo_t            tempo_q;  // tempo latched at period start
	logic              beat_end;

	assign sample_tick = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
	assign beat_end    = (beat_cnt == BEAT_W'(BEAT_UNIT - 1));
	assign step_tick   = play & beat_end & (unit_cnt == tempo_q);

	// free-running sample divider, ignores play
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			div_cnt <= '0;
		else if (sample_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || !play)
		begin
			beat_cnt <= '0;
			unit_cnt <= '0;
			tempo_q  <= tempo; // next period starts from the current tempo
		end
		else if (beat_end)
		begin
			beat_cnt <= '0;
			if (unit_cnt == tempo_q)
			begin
				unit_cnt <= '0;
				tempo_q  <= tempo;
			end
			else
				unit_cnt <= unit_cnt + 1'b1;
		end
		else
			beat_cnt <= beat_cnt + 1'b1;
	end

endmodule

`default_nettype wire

//--- logic/drum_pkg.sv
`default_nettype none

package drum_pkg;

	// voice and pattern geometry
	localparam int NUM_VOICES = 4;
	localparam int NUM_STEPS  = 8;
	localparam int STEP_BITS  = 3;

	typedef logic signed [7:0] sample_t; // one voice output
	typedef logic signed [9:0] mix_t;    // four voices summed, no clipping needed
	typedef logic [7:0]        pattern_t; // bit s fires on step s
	typedef logic [7:0]        tempo_t;   // step period = (tempo + 1) beat units
	typedef logic [2:0]        cfg_addr_t;

	// configuration map
	localparam cfg_addr_t CFG_PAT0  = 3'd0;
	localparam cfg_addr_t CFG_PAT1  = 3'd1;
	localparam cfg_addr_t CFG_PAT2  = 3'd2;
	localparam cfg_addr_t CFG_PAT3  = 3'd3;
	localparam cfg_addr_t CFG_TEMPO = 3'd4;

	// per-voice tables, kick, snare, hat, clap
	localparam logic [7:0] VOICE_PEAK [NUM_VOICES] = '{8'd120, 8'd100, 8'd80, 8'd60};

	// square-wave half period in sample ticks
	localparam logic [7:0] VOICE_HALF [NUM_VOICES] = '{8'd8, 8'd4, 8'd2, 8'd1};

	// level drop at every half-period edge
	localparam logic [7:0] VOICE_DECAY [NUM_VOICES] = '{8'd4, 8'd5, 8'd8, 8'd6};

endpackage

`default_nettype wire
